// ==== src/mdu_settings.svh ====
/*
 * Width settings for the multiply/divide unit.
 * Included by the package and by the RTL that sizes its datapath.
 */

`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// Operand and result width
`define MDU_XLEN 32

// Half word for the 16x16 partial products
`define MDU_HALF 16

// Enough bits to index every quotient bit
`define MDU_CNT_W 5

`endif

// ==== src/mdu_pkg.sv ====
/*
 * Shared types of the multiply/divide unit.
 * Operand vectors, operator and state encodings, request and response.
 */

`default_nettype none

`include "mdu_settings.svh"

package mdu_pkg;

  // Plain vectors
  typedef logic [`MDU_XLEN-1:0]         word_t;
  typedef logic [`MDU_HALF-1:0]         half_t;
  typedef logic signed [2*`MDU_HALF+1:0] prod_t;
  typedef logic [`MDU_CNT_W-1:0]        div_cnt_t;

  // Divide forms have the top bit set
  typedef enum logic [2:0] {
    MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
  } md_op_e;

  typedef enum logic {MULT_LOW, MULT_HIGH} mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

  typedef struct packed {
    md_op_e op;
    word_t  operand_a;
    word_t  operand_b;
  } md_req_t;

  typedef struct packed {
    logic  valid;
    word_t result;
  } md_resp_t;

endpackage

`default_nettype wire

// ==== src/mdu_mult.sv ====
/*
 * Two-state 16x16 partial-product multiplier for MUL, MULH, MULHSU, MULHU.
 * The low word is ready in MULT_LOW, the high word one cycle later.
 */

`timescale 1ns/1ps
`default_nettype none

`include "mdu_settings.svh"

module mdu_mult (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  mdu_pkg::md_req_t  req_i,
  input  logic              ready_i,
  output mdu_pkg::md_resp_t resp_o
);

  mdu_pkg::md_req_t     req_q;
  mdu_pkg::mult_state_e state_q;
  logic                 active_q;
  mdu_pkg::prod_t       upper_q;

  logic                     sign_a, sign_b;
  logic                     high_op;
  logic                     mult_valid;
  mdu_pkg::half_t           a_lo, a_hi, b_lo, b_hi;
  logic signed [`MDU_HALF:0] a_lo_x, a_hi_x, b_lo_x, b_hi_x;
  logic signed [`MDU_HALF:0] mult3_a;
  mdu_pkg::prod_t           prod_ll, prod_hl, prod_x;
  mdu_pkg::prod_t           ll_upper, psum, high_sum;
  mdu_pkg::word_t           low_word;

  //////////////////////////////
  // Operands and signs
  //////////////////////////////

  assign a_lo = req_q.operand_a[`MDU_HALF-1:0];
  assign a_hi = req_q.operand_a[`MDU_XLEN-1:`MDU_HALF];
  assign b_lo = req_q.operand_b[`MDU_HALF-1:0];
  assign b_hi = req_q.operand_b[`MDU_XLEN-1:`MDU_HALF];

  // MULH signs both operands and MULHSU only A
  assign sign_a  = (req_q.op == mdu_pkg::MD_MULH) | (req_q.op == mdu_pkg::MD_MULHSU);
  assign sign_b  = (req_q.op == mdu_pkg::MD_MULH);
  assign high_op = (req_q.op != mdu_pkg::MD_MUL);

  // Low halves never carry a sign
  assign a_lo_x = $signed({1'b0, a_lo});
  assign b_lo_x = $signed({1'b0, b_lo});
  assign a_hi_x = $signed({sign_a & a_hi[`MDU_HALF-1], a_hi});
  assign b_hi_x = $signed({sign_b & b_hi[`MDU_HALF-1], b_hi});

  //////////////////////////////
  // Partial products
  //////////////////////////////

  // Third multiplier does LH in the low state, HH in the high state
  assign mult3_a = (state_q == mdu_pkg::MULT_HIGH) ? a_hi_x : a_lo_x;

  assign prod_ll = a_lo_x * b_lo_x;
  assign prod_hl = a_hi_x * b_lo_x;
  assign prod_x  = mult3_a * b_hi_x;

  // Zero extended carry part of LL
  assign ll_upper = $signed({{(`MDU_HALF+2){1'b0}}, prod_ll[2*`MDU_HALF-1:`MDU_HALF]});

  // Middle sum is exact in 34 bits for every sign mode
  assign psum     = ll_upper + prod_hl + prod_x;
  assign low_word = {psum[`MDU_HALF-1:0], prod_ll[`MDU_HALF-1:0]};

  // Stored upper part is already sign extended
  assign high_sum = prod_x + upper_q;

  assign mult_valid = active_q & ((state_q == mdu_pkg::MULT_HIGH) | ~high_op);

  assign resp_o.valid  = mult_valid;
  assign resp_o.result = (state_q == mdu_pkg::MULT_HIGH) ? high_sum[`MDU_XLEN-1:0] : low_word;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      state_q  <= mdu_pkg::MULT_LOW;
    end else if (start_i && !active_q) begin
      active_q <= 1'b1;
      state_q  <= mdu_pkg::MULT_LOW;
    end else if (active_q) begin
      if (!mult_valid) begin
        // High forms step on once the upper sum is stored
        state_q <= mdu_pkg::MULT_HIGH;
      end else if (ready_i) begin
        active_q <= 1'b0;
        state_q  <= mdu_pkg::MULT_LOW;
      end
    end
  end

  // Operands and intermediate sum
  always_ff @(posedge clk_i) begin
    if (start_i && !active_q) begin
      req_q <= req_i;
    end
    if (active_q && (state_q == mdu_pkg::MULT_LOW) && high_op) begin
      upper_q <= psum >>> `MDU_HALF;
    end
  end

endmodule

`default_nettype wire

// ==== src/mdu_div.sv ====
/*
 * Iterative restoring divider for DIV, DIVU, REM and REMU.
 * One subtractor serves the absolute values, the compares and the final negation.
 */

`timescale 1ns/1ps
`default_nettype none

`include "mdu_settings.svh"

module mdu_div (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  mdu_pkg::md_req_t  req_i,
  input  logic              ready_i,
  output mdu_pkg::md_resp_t resp_o
);

  mdu_pkg::div_state_e state_q, state_d;
  mdu_pkg::div_cnt_t   cnt_q, cnt_d, cnt_dec;
  logic                by_zero_q, by_zero_d;
  mdu_pkg::md_req_t    req_q;

  // Extra top bit keeps the bit shifted out of a large remainder
  logic [`MDU_XLEN:0]  rem_q, rem_d;
  mdu_pkg::word_t      den_q, den_d;
  mdu_pkg::word_t      numer_q, numer_d;
  mdu_pkg::word_t      quot_q, quot_d;

  logic [`MDU_XLEN:0]   sub_a, sub_b;
  logic [`MDU_XLEN+1:0] sub_res;
  logic                 is_ge;
  mdu_pkg::word_t       one_shift, next_rem, next_quot;
  logic                 b_zero, rem_req, is_rem, is_signed;
  logic                 sign_a, sign_b, change_sign;

  //////////////////////////////
  // Subtractor and compare
  //////////////////////////////

  // Borrow out means remainder below divisor
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  assign is_ge   = ~sub_res[`MDU_XLEN+1];

  assign cnt_dec   = cnt_q - 1'b1;
  assign one_shift = mdu_pkg::word_t'(1) << cnt_q;
  assign next_rem  = is_ge ? sub_res[`MDU_XLEN-1:0] : rem_q[`MDU_XLEN-1:0];
  assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;

  // Decode of the incoming request
  assign b_zero  = (req_i.operand_b == '0);
  assign rem_req = (req_i.op == mdu_pkg::MD_REM) | (req_i.op == mdu_pkg::MD_REMU);

  // Decode of the running request
  assign is_rem    = (req_q.op == mdu_pkg::MD_REM) | (req_q.op == mdu_pkg::MD_REMU);
  assign is_signed = (req_q.op == mdu_pkg::MD_DIV) | (req_q.op == mdu_pkg::MD_REM);
  assign sign_a    = req_q.operand_a[`MDU_XLEN-1] & is_signed;
  assign sign_b    = req_q.operand_b[`MDU_XLEN-1] & is_signed;

  // Remainder follows the dividend
  assign change_sign = is_rem ? sign_a : ((sign_a ^ sign_b) & ~by_zero_q);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    by_zero_d = by_zero_q;
    rem_d     = rem_q;
    den_d     = den_q;
    numer_d   = numer_q;
    quot_d    = quot_q;
    // Compare is the default use of the subtractor
    sub_a     = rem_q;
    sub_b     = {1'b0, den_q};

    unique case (state_q)
      mdu_pkg::DIV_IDLE: begin
        if (start_i) begin
          by_zero_d = b_zero;
          // Preset the divide by zero result
          rem_d     = rem_req ? {1'b0, req_i.operand_a} : {1'b0, {`MDU_XLEN{1'b1}}};
          state_d   = b_zero ? mdu_pkg::DIV_FINISH : mdu_pkg::DIV_ABS_A;
        end
      end

      mdu_pkg::DIV_ABS_A: begin
        sub_a   = '0;
        sub_b   = {1'b0, req_q.operand_a};
        numer_d = sign_a ? sub_res[`MDU_XLEN-1:0] : req_q.operand_a;
        quot_d  = '0;
        state_d = mdu_pkg::DIV_ABS_B;
      end

      mdu_pkg::DIV_ABS_B: begin
        sub_a   = '0;
        sub_b   = {1'b0, req_q.operand_b};
        den_d   = sign_b ? sub_res[`MDU_XLEN-1:0] : req_q.operand_b;
        // First remainder is the dividend MSB
        rem_d   = {{`MDU_XLEN{1'b0}}, numer_q[`MDU_XLEN-1]};
        cnt_d   = mdu_pkg::div_cnt_t'(`MDU_XLEN-1);
        state_d = mdu_pkg::DIV_COMP;
      end

      mdu_pkg::DIV_COMP: begin
        rem_d   = {next_rem, numer_q[cnt_dec]};
        quot_d  = next_quot;
        cnt_d   = cnt_dec;
        state_d = (cnt_q == 1) ? mdu_pkg::DIV_LAST : mdu_pkg::DIV_COMP;
      end

      mdu_pkg::DIV_LAST: begin
        // Only the wanted result is kept from here on
        rem_d   = {1'b0, (is_rem ? next_rem : next_quot)};
        state_d = mdu_pkg::DIV_SIGN;
      end

      mdu_pkg::DIV_SIGN: begin
        sub_a   = '0;
        sub_b   = {1'b0, rem_q[`MDU_XLEN-1:0]};
        rem_d   = change_sign ? {1'b0, sub_res[`MDU_XLEN-1:0]} : rem_q;
        state_d = mdu_pkg::DIV_FINISH;
      end

      mdu_pkg::DIV_FINISH: begin
        // Hold the result until the consumer takes it
        if (ready_i) begin
          state_d = mdu_pkg::DIV_IDLE;
        end
      end

      default: begin
        state_d = mdu_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= mdu_pkg::DIV_IDLE;
      cnt_q     <= '0;
      by_zero_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      by_zero_q <= by_zero_d;
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if ((state_q == mdu_pkg::DIV_IDLE) && start_i) begin
      req_q <= req_i;
    end
    rem_q   <= rem_d;
    den_q   <= den_d;
    numer_q <= numer_d;
    quot_q  <= quot_d;
  end

  assign resp_o.valid  = (state_q == mdu_pkg::DIV_FINISH);
  assign resp_o.result = rem_q[`MDU_XLEN-1:0];

endmodule

`default_nettype wire

// ==== src/mdu_complete.sv ====
/*
 * Completion stage of the multiply/divide unit.
 * Routes an accepted start to one unit and returns its result to the consumer.
 */

`timescale 1ns/1ps
`default_nettype none

module mdu_complete (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  mdu_pkg::md_req_t  req_i,
  input  logic              ready_i,
  input  mdu_pkg::md_resp_t mult_resp_i,
  input  mdu_pkg::md_resp_t div_resp_i,
  output logic              mult_start_o,
  output logic              div_start_o,
  output logic              mult_ready_o,
  output logic              div_ready_o,
  output logic              busy_o,
  output logic              valid_o,
  output mdu_pkg::word_t    result_o
);

  logic              busy_q;
  logic              sel_div_q;
  logic              accept;
  logic              req_is_div;
  mdu_pkg::md_resp_t resp_sel;

  // Starts while busy are dropped
  assign accept     = start_i & ~busy_q;
  assign req_is_div = req_i.op inside {mdu_pkg::MD_DIV, mdu_pkg::MD_DIVU,
                                       mdu_pkg::MD_REM, mdu_pkg::MD_REMU};

  assign mult_start_o = accept & ~req_is_div;
  assign div_start_o  = accept & req_is_div;

  // Ready reaches only the unit in flight
  assign mult_ready_o = ready_i & busy_q & ~sel_div_q;
  assign div_ready_o  = ready_i & busy_q & sel_div_q;

  assign resp_sel = sel_div_q ? div_resp_i : mult_resp_i;
  assign valid_o  = busy_q & resp_sel.valid;
  assign result_o = resp_sel.result;
  assign busy_o   = busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      sel_div_q <= 1'b0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      sel_div_q <= req_is_div;
    end else if (valid_o && ready_i) begin
      // Result taken, free for the next start
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/mdu_top.sv ====
/*
 * Top of the RV32M multiply/divide unit.
 * Start with a pulse when not busy, take the result while valid and ready.
 */

`timescale 1ns/1ps
`default_nettype none

module mdu_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  mdu_pkg::md_req_t req_i,
  input  logic             ready_i,
  output logic             busy_o,
  output logic             valid_o,
  output mdu_pkg::word_t   result_o
);

  // Unit handshakes
  logic              mult_start, div_start;
  logic              mult_ready, div_ready;
  mdu_pkg::md_resp_t mult_resp, div_resp;

  mdu_complete u_mdu_complete (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .req_i        (req_i),
    .ready_i      (ready_i),
    .mult_resp_i  (mult_resp),
    .div_resp_i   (div_resp),
    .mult_start_o (mult_start),
    .div_start_o  (div_start),
    .mult_ready_o (mult_ready),
    .div_ready_o  (div_ready),
    .busy_o       (busy_o),
    .valid_o      (valid_o),
    .result_o     (result_o)
  );

  mdu_mult u_mdu_mult (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (mult_start),
    .req_i   (req_i),
    .ready_i (mult_ready),
    .resp_o  (mult_resp)
  );

  mdu_div u_mdu_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (div_start),
    .req_i   (req_i),
    .ready_i (div_ready),
    .resp_o  (div_resp)
  );

endmodule

`default_nettype wire

// ==== sim/tb_mdu.sv ====
/*
 * Directed testbench for the multiply/divide unit.
 * Checks latency, results, back-pressure and busy handling against an RV32M model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mdu;

  localparam int WAIT_LIMIT = 100;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              start_i;
  mdu_pkg::md_req_t  req_i;
  logic              ready_i;
  logic              busy_o;
  logic              valid_o;
  mdu_pkg::word_t    result_o;

  int          checks;
  int          errors;
  int          timeouts;
  logic [15:0] lfsr_q;

  mdu_top u_mdu_top (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .busy_o   (busy_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  //////////////////////////////
  // Stimulus and model
  //////////////////////////////

  // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One step per bit taken
  task automatic rand_word(output mdu_pkg::word_t w);
    int i;
    for (i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  function automatic mdu_pkg::word_t model(input mdu_pkg::md_op_e op,
                                           input mdu_pkg::word_t a,
                                           input mdu_pkg::word_t b);
    logic signed [63:0] sa, sb, ua, ub, prod;
    logic signed [31:0] s_quo, s_rem;
    logic               ovf;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'h0, a};
    ub  = {32'h0, b};
    // Most negative over minus one
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    // Signed quotient and remainder outside the special cases
    s_quo = '0;
    s_rem = '0;
    if ((b != '0) && !ovf) begin
      s_quo = $signed(a) / $signed(b);
      s_rem = $signed(a) % $signed(b);
    end
    case (op)
      mdu_pkg::MD_MULH:   prod = sa * sb;
      mdu_pkg::MD_MULHSU: prod = sa * ub;
      default:            prod = ua * ub;
    endcase
    case (op)
      mdu_pkg::MD_MUL:  model = prod[31:0];
      mdu_pkg::MD_DIV:  model = (b == 0) ? '1 : ovf ? a : s_quo;
      mdu_pkg::MD_DIVU: model = (b == 0) ? '1 : a / b;
      mdu_pkg::MD_REM:  model = (b == 0) ? a : ovf ? '0 : s_rem;
      mdu_pkg::MD_REMU: model = (b == 0) ? a : a % b;
      default:          model = prod[63:32];
    endcase
  endfunction

  // Cycles from the start edge to valid
  function automatic int latency(input mdu_pkg::md_op_e op, input mdu_pkg::word_t b);
    if (op == mdu_pkg::MD_MUL) return 1;
    if (op inside {mdu_pkg::MD_MULH, mdu_pkg::MD_MULHSU, mdu_pkg::MD_MULHU}) return 2;
    return (b == '0) ? 1 : 36;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input mdu_pkg::word_t got,
                            input mdu_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Handshake helpers
  //////////////////////////////

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (busy_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (busy_o) begin
      timeouts++;
      $display("Timeout at %0t ns: busy_o never fell", $time);
    end
  endtask

  // Returns at the end of the start edge
  task automatic launch(input mdu_pkg::md_op_e op, input mdu_pkg::word_t a,
                        input mdu_pkg::word_t b);
    mdu_pkg::md_req_t req;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    @(posedge clk_i);
    start_i <= 1'b1;
    req_i   <= req;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // Sampled at the falling edge away from DUT updates
  task automatic wait_valid(output int cycles, output logic seen);
    @(negedge clk_i);
    cycles = 1;
    while (!valid_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    seen = valid_o;
    if (!seen) begin
      timeouts++;
      $display("Timeout at %0t ns: valid_o never rose", $time);
    end
  endtask

  task automatic run_op(input mdu_pkg::md_op_e op, input mdu_pkg::word_t a,
                        input mdu_pkg::word_t b);
    int   cycles;
    logic seen;
    wait_idle();
    launch(op, a, b);
    wait_valid(cycles, seen);
    if (seen) begin
      check_cycles($sformatf("latency %s", op.name()), cycles, latency(op, b));
      check_word($sformatf("result_o %s", op.name()), result_o, model(op, a, b));
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    @(negedge clk_i);
    check_flag("busy_o after reset", busy_o, 1'b0);
    check_flag("valid_o after reset", valid_o, 1'b0);
  endtask

  task automatic test_mult();
    mdu_pkg::word_t corner [4];
    mdu_pkg::word_t a, b;
    int             i, j, k;
    corner = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    for (k = 0; k < 4; k++) begin
      for (i = 0; i < 4; i++) begin
        for (j = 0; j < 4; j++) begin
          run_op(mdu_pkg::md_op_e'(k[2:0]), corner[i], corner[j]);
        end
      end
    end
    for (i = 0; i < 40; i++) begin
      rand_word(a);
      rand_word(b);
      for (k = 0; k < 4; k++) begin
        run_op(mdu_pkg::md_op_e'(k[2:0]), a, b);
      end
    end
  endtask

  task automatic test_div();
    mdu_pkg::word_t da [8];
    mdu_pkg::word_t db [8];
    mdu_pkg::word_t a, b;
    int             i, k;
    // Mixed signs, overflow case and a few edges
    da = '{32'h64, 32'hFFFF_FF9C, 32'h64, 32'hFFFF_FF9C,
           32'h7, 32'h8000_0000, 32'h8000_0000, 32'h7FFF_FFFF};
    db = '{32'h7, 32'h7, 32'hFFFF_FFF9, 32'hFFFF_FFF9,
           32'h64, 32'hFFFF_FFFF, 32'h3, 32'hFFFF_FFFE};
    for (k = 4; k < 8; k++) begin
      for (i = 0; i < 8; i++) begin
        run_op(mdu_pkg::md_op_e'(k[2:0]), da[i], db[i]);
      end
    end
    for (i = 0; i < 20; i++) begin
      rand_word(a);
      rand_word(b);
      // Spread divisor sizes
      b = b >> b[3:0];
      if (b == '0) begin
        b = 32'h1;
      end
      for (k = 4; k < 8; k++) begin
        run_op(mdu_pkg::md_op_e'(k[2:0]), a, b);
      end
    end
  endtask

  task automatic test_div_zero();
    mdu_pkg::word_t za [3];
    int             i, k;
    za = '{32'h0000_3039, 32'hFFFF_FFFB, 32'h8000_0000};
    for (k = 4; k < 8; k++) begin
      for (i = 0; i < 3; i++) begin
        run_op(mdu_pkg::md_op_e'(k[2:0]), za[i], 32'h0);
      end
    end
  endtask

  task automatic test_backpressure(input mdu_pkg::md_op_e op, input mdu_pkg::word_t a,
                                   input mdu_pkg::word_t b);
    int             cycles;
    logic           seen;
    mdu_pkg::word_t held;
    wait_idle();
    @(posedge clk_i);
    ready_i <= 1'b0;
    launch(op, a, b);
    wait_valid(cycles, seen);
    if (seen) begin
      held = result_o;
      check_word("result_o under back-pressure", held, model(op, a, b));
      repeat (5) begin
        @(negedge clk_i);
        check_flag("valid_o held", valid_o, 1'b1);
        check_word("result_o held", result_o, held);
      end
    end
    @(posedge clk_i);
    ready_i <= 1'b1;
    if (seen) begin
      @(negedge clk_i);
      check_flag("busy_o before completion", busy_o, 1'b1);
      check_flag("valid_o before completion", valid_o, 1'b1);
      // Completion edge lies between these samples
      @(negedge clk_i);
      check_flag("busy_o after completion", busy_o, 1'b0);
      check_flag("valid_o after completion", valid_o, 1'b0);
    end
  endtask

  task automatic test_busy_start();
    mdu_pkg::md_req_t other;
    int               cycles, extra;
    logic             seen;
    other.op        = mdu_pkg::MD_MUL;
    other.operand_a = 32'h5;
    other.operand_b = 32'h6;
    extra           = 0;
    wait_idle();
    launch(mdu_pkg::MD_DIV, 32'hFFFF_F000, 32'h0000_0013);
    // Second pulse lands while the divide runs
    @(posedge clk_i);
    start_i <= 1'b1;
    req_i   <= other;
    @(posedge clk_i);
    start_i <= 1'b0;
    wait_valid(cycles, seen);
    if (seen) begin
      check_word("result_o with ignored start", result_o,
                 model(mdu_pkg::MD_DIV, 32'hFFFF_F000, 32'h0000_0013));
    end
    repeat (40) begin
      @(negedge clk_i);
      if (valid_o) begin
        extra++;
      end
    end
    check_cycles("extra valid cycles", extra, 0);
    check_flag("busy_o after ignored start", busy_o, 1'b0);
  endtask

  initial begin
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    lfsr_q   = 16'd27483;
    rst_ni   = 1'b0;
    start_i  = 1'b0;
    req_i    = '0;
    ready_i  = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_mult();
    test_div();
    test_div_zero();
    test_backpressure(mdu_pkg::MD_DIV, 32'hFFFF_FF9C, 32'h0000_0007);
    test_backpressure(mdu_pkg::MD_MULHU, 32'hDEAD_BEEF, 32'h1234_5678);
    test_busy_start();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mdu.f ====
+incdir+src
src/mdu_pkg.sv
src/mdu_mult.sv
src/mdu_div.sv
src/mdu_complete.sv
src/mdu_top.sv
sim/tb_mdu.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f mdu.f --top-module tb_mdu --Mdir $(OBJ_DIR) -o tb_mdu

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/tb_mdu | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
